/* Makefile */
# Verilator build and run for the stream FIFO testbench

SIM      ?= verilator
TOP      ?= tb_stream_fifo
FILELIST ?= src.f
BUILD    ?= obj_dir
LOG      ?= sim.log
VFLAGS   ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides, a missing pass line also counts as failure
run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/tb_clock_gen.sv */
`default_nettype none

// clock and reset source for the testbench
module tb_clock_gen #(
	parameter int RST_CYCLES = 5
) (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// active low, released on a rising edge
	initial begin
		rst = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

`default_nettype wire

/* bench/tb_stream_fifo.sv */
`default_nettype none

// directed tests for the stream FIFO
module tb_stream_fifo;

	timeunit 1ns;
	timeprecision 100ps;

	// default depth of the DUT, plus two beats in the read stage
	localparam int DEPTH    = 16;
	localparam int CAPACITY = DEPTH + 2;
	localparam int TH       = 2;
	localparam int TIMEOUT  = 300;

	logic                   clk;
	logic                   rst;
	logic                   clr;
	stream_pkg::beat_t      in_data;
	logic                   in_valid;
	logic                   in_ready;
	stream_pkg::beat_t      out_data;
	logic                   out_valid;
	logic                   out_ready;
	fifo_pkg::fifo_status_t status;

	// accepted beats still owed by the output
	stream_pkg::beat_t      sb[$];
	stream_pkg::beat_t      stall_beat;
	fifo_pkg::fifo_status_t seen_status;
	logic                   seen_valid;
	logic                   seen_ready;
	logic                   stalled;
	logic                   in_fired;
	logic                   gap_count_on;
	logic                   random_ready;
	int                     n_out;
	int                     gaps;
	int                     errors;
	int                     n_checks;
	int                     n_tests;
	int                     test_errors;

	tb_clock_gen i_clock_gen (
		.clk(clk),
		.rst(rst)
	);

	stream_fifo_top i_stream_fifo_top (
		.clk      (clk),
		.rst      (rst),
		.clr      (clr),
		.in_data  (in_data),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.out_data (out_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.status   (status)
	);

	//////////////////////////////
	// compare tasks

	task automatic check_beat(input string what, input stream_pkg::beat_t got,
			input stream_pkg::beat_t exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED @%0t: %s got %h/%b expected %h/%b", $time, what,
				got.data, got.last, exp.data, exp.last);
		end
	endtask

	task automatic check_status(input string what, input fifo_pkg::fifo_status_t got,
			input fifo_pkg::fifo_status_t exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED @%0t: %s got f%b e%b af%b ae%b %s expected f%b e%b af%b ae%b %s",
				$time, what, got.full, got.empty, got.almost_full, got.almost_empty,
				got.level.name(), exp.full, exp.empty, exp.almost_full, exp.almost_empty,
				exp.level.name());
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		n_checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED @%0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	//////////////////////////////
	// helpers

	function automatic stream_pkg::beat_t rand_beat();
		stream_pkg::beat_t b;
		b.data = {$urandom, $urandom, $urandom, $urandom};
		b.last = 1'($urandom);
		return b;
	endfunction

	// status expected for a given RAM occupancy
	function automatic fifo_pkg::fifo_status_t predict_status(input int occ);
		fifo_pkg::fifo_status_t s;
		s.full         = occ == DEPTH;
		s.empty        = occ == 0;
		s.almost_full  = occ > DEPTH - TH;
		s.almost_empty = occ < TH;
		// quarters of the depth, a full RAM sits in the top quarter
		if (occ >= DEPTH * 3 / 4)
			s.level = fifo_pkg::LEVEL_HIGH;
		else if (occ >= DEPTH / 2)
			s.level = fifo_pkg::LEVEL_HALF;
		else if (occ >= DEPTH / 4)
			s.level = fifo_pkg::LEVEL_QUARTER;
		else
			s.level = fifo_pkg::LEVEL_LOW;
		return s;
	endfunction

	task automatic timed_out(input string what);
		errors++;
		$display("timeout at %0t ns while waiting for %s", $time, what);
		$display("STATUS: FAIL");
		$finish;
	endtask

	// one clock cycle, outputs sampled at the falling edge
	task automatic tick();
		@(negedge clk);
		in_fired    = 1'b0;
		seen_status = status;
		seen_valid  = out_valid;
		seen_ready  = in_ready;
		if (clr) begin
			sb.delete();
			stalled = 1'b0;
		end else begin
			// a stalled beat must hold still
			if (stalled) begin
				check_bit("out_valid in stall", out_valid, 1'b1);
				check_beat("out_data in stall", out_data, stall_beat);
			end
			if (gap_count_on && n_out > 0 && sb.size() > 0 && !out_valid)
				gaps++;
			if (out_valid && out_ready) begin
				if (sb.size() == 0) begin
					errors++;
					$display("output gave a beat at %0t ns that was never written", $time);
				end else begin
					check_beat("output order", out_data, sb.pop_front());
				end
				n_out++;
			end
			if (in_valid && in_ready) begin
				sb.push_back(in_data);
				in_fired = 1'b1;
			end
			stalled    = out_valid && !out_ready;
			stall_beat = out_data;
		end
		@(posedge clk);
		if (random_ready)
			out_ready <= 1'($urandom);
	endtask

	// holds in_valid until the beat is taken
	task automatic send_beat(input stream_pkg::beat_t b);
		int t;
		t = 0;
		in_data  <= b;
		in_valid <= 1'b1;
		do begin
			tick();
			t++;
			if (t > TIMEOUT)
				timed_out("in_ready");
		end while (!in_fired);
	endtask

	task automatic drain();
		int t;
		t = 0;
		out_ready <= 1'b1;
		while (sb.size() > 0) begin
			tick();
			t++;
			if (t > TIMEOUT)
				timed_out("the output to drain");
		end
		out_ready <= 1'b0;
	endtask

	// edges from acceptance until out_valid shows
	task automatic wait_out_valid(output int edges);
		edges = 0;
		forever begin
			tick();
			if (seen_valid)
				break;
			edges++;
			if (edges > TIMEOUT)
				timed_out("out_valid");
		end
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("test %-8s %s, %0d errors", name,
			(errors == test_errors) ? "ok" : "failed", errors - test_errors);
		test_errors = errors;
	endtask

	//////////////////////////////
	// directed tests

	task automatic test_reset();
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				timed_out("reset release");
		end while (!rst);
		check_status("status after reset", status, predict_status(0));
		check_bit("in_ready after reset", in_ready, 1'b1);
		check_bit("out_valid after reset", out_valid, 1'b0);
		@(posedge clk);
		end_test("reset");
	endtask

	task automatic test_order();
		int edges;
		n_out = 0;
		send_beat(rand_beat());
		in_valid <= 1'b0;
		wait_out_valid(edges);
		// read at k+1, captured at k+2
		check_count("edges to out_valid", edges, 2);
		drain();
		// 40 beats streaming with out_ready held high
		n_out        = 0;
		gaps         = 0;
		gap_count_on = 1'b1;
		out_ready <= 1'b1;
		for (int i = 0; i < 40; i++)
			send_beat(rand_beat());
		in_valid <= 1'b0;
		drain();
		gap_count_on = 1'b0;
		check_count("idle cycles in burst", gaps, 0);
		check_count("burst beats out", n_out, 40);
		end_test("order");
	endtask

	task automatic test_capacity();
		int accepted;
		int t;
		accepted = 0;
		n_out    = 0;
		in_data  <= rand_beat();
		in_valid <= 1'b1;
		for (t = 0; t < TIMEOUT; t++) begin
			tick();
			if (!in_fired)
				break;
			accepted++;
			in_data <= rand_beat();
		end
		if (t == TIMEOUT)
			timed_out("in_ready to fall");
		in_valid <= 1'b0;
		check_count("beats accepted", accepted, CAPACITY);
		check_status("status when full", seen_status, predict_status(DEPTH));
		check_bit("out_valid when full", seen_valid, 1'b1);
		drain();
		check_count("beats drained", n_out, CAPACITY);
		end_test("capacity");
	endtask

	task automatic test_flags();
		int edges;
		int occ;
		n_out = 0;
		for (int n = 1; n <= CAPACITY; n++) begin
			send_beat(rand_beat());
			in_valid <= 1'b0;
			wait_out_valid(edges);
			// let the read stage take its two beats
			tick();
			tick();
			occ = (n >= 2) ? n - 2 : 0;
			check_status("status per write", seen_status, predict_status(occ));
			check_bit("in_ready per write", seen_ready, occ < DEPTH);
		end
		drain();
		check_count("beats drained", n_out, CAPACITY);
		end_test("flags");
	endtask

	task automatic test_stall();
		n_out        = 0;
		random_ready = 1'b1;
		for (int i = 0; i < 60; i++)
			send_beat(rand_beat());
		in_valid <= 1'b0;
		random_ready = 1'b0;
		drain();
		check_count("beats through stalls", n_out, 60);
		end_test("stall");
	endtask

	task automatic test_clear();
		for (int i = 0; i < 6; i++)
			send_beat(rand_beat());
		in_valid <= 1'b0;
		clr <= 1'b1;
		tick();
		clr <= 1'b0;
		tick();
		check_status("status after clear", seen_status, predict_status(0));
		check_bit("out_valid after clear", seen_valid, 1'b0);
		check_bit("in_ready after clear", seen_ready, 1'b1);
		// fresh beats only, any stale one fails the order check
		n_out = 0;
		for (int i = 0; i < 3; i++)
			send_beat(rand_beat());
		in_valid <= 1'b0;
		drain();
		check_count("beats after clear", n_out, 3);
		tick();
		check_bit("out_valid once drained", seen_valid, 1'b0);
		check_status("status once drained", seen_status, predict_status(0));
		end_test("clear");
	endtask

	initial begin
		void'($urandom(32'h6d1b_d022));
		clr       <= 1'b0;
		in_data   <= '0;
		in_valid  <= 1'b0;
		out_ready <= 1'b0;
		stalled      = 1'b0;
		gap_count_on = 1'b0;
		random_ready = 1'b0;
		errors       = 0;
		n_checks     = 0;
		n_tests      = 0;
		test_errors  = 0;
		test_reset();
		test_order();
		test_capacity();
		test_flags();
		test_stall();
		test_clear();
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
verilog/stream_pkg.sv
verilog/fifo_pkg.sv
verilog/fifo_ram.sv
verilog/fifo_ctrl.sv
verilog/fifo_read_stage.sv
verilog/stream_fifo_top.sv
bench/tb_clock_gen.sv
bench/tb_stream_fifo.sv

/* verilog/fifo_ctrl.sv */
`default_nettype none

// pointer, guard bit and flag logic of the FIFO
module fifo_ctrl #(
	parameter int ADDR_WIDTH = 4,
	parameter int AEMPTY_TH  = 2,
	parameter int AFULL_TH   = 2
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   clr,
	input  logic                   wr_req,
	input  logic                   rd_en,
	output logic                   wr_en,
	output logic [ADDR_WIDTH-1:0]  wr_addr,
	output logic [ADDR_WIDTH-1:0]  rd_addr,
	output logic                   rd_avail,
	output fifo_pkg::fifo_status_t status
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [ADDR_WIDTH-1:0] wp;
	logic [ADDR_WIDTH-1:0] wp_pl1;
	logic [ADDR_WIDTH-1:0] wp_pl2;
	logic [ADDR_WIDTH-1:0] rp;
	logic [ADDR_WIDTH-1:0] rp_pl1;
	// one step ahead, set while count is at depth-1 or above
	logic                  gb2;
	logic [ADDR_WIDTH:0]   cnt;
	logic [ADDR_WIDTH:0]   cnt_nxt;
	logic                  wr_only;
	logic                  rd_only;

	// full decided here only, top feeds the same inverse as in_ready
	assign wr_en   = wr_req & ~status.full;
	assign wr_only = wr_en & ~rd_en;
	assign rd_only = rd_en & ~wr_en;

	assign wp_pl1 = wp + ADDR_WIDTH'(1);
	assign wp_pl2 = wp + ADDR_WIDTH'(2);
	assign rp_pl1 = rp + ADDR_WIDTH'(1);

	assign wr_addr  = wp;
	assign rd_addr  = rp;
	assign rd_avail = ~status.empty;

	//////////////////////////////
	// pointers and guard bits

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			wp <= '0;
			rp <= '0;
		end else begin
			if (wr_en)
				wp <= wp_pl1;
			if (rd_en)
				rp <= rp_pl1;
		end
	end

	// write leaving one slot free sets it, a read below full clears it
	always_ff @(posedge clk) begin
		if (!rst || clr)
			gb2 <= 1'b0;
		else if (wr_only && wp_pl2 == rp)
			gb2 <= 1'b1;
		else if (rd_only && wp != rp)
			gb2 <= 1'b0;
	end

	//////////////////////////////
	// count and registered flags

	// simultaneous write and read leave the count alone
	always_comb begin
		cnt_nxt = cnt;
		if (wr_only)
			cnt_nxt = cnt + 1'b1;
		else if (rd_only)
			cnt_nxt = cnt - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			cnt                 <= '0;
			status.full         <= 1'b0;
			status.empty        <= 1'b1;
			status.almost_full  <= 1'b0;
			status.almost_empty <= 1'b1;
			status.level        <= fifo_pkg::LEVEL_LOW;
		end else begin
			cnt <= cnt_nxt;
			// last free slot taken
			if (wr_only && gb2 && wp_pl1 == rp)
				status.full <= 1'b1;
			else if (rd_only)
				status.full <= 1'b0;
			// last stored beat read out
			if (wr_only)
				status.empty <= 1'b0;
			else if (rd_only && rp_pl1 == wp && !gb2)
				status.empty <= 1'b1;
			status.almost_full  <= int'(cnt_nxt) > DEPTH - AFULL_TH;
			status.almost_empty <= int'(cnt_nxt) < AEMPTY_TH;
			// overflow bit only set at exactly depth
			if (cnt_nxt[ADDR_WIDTH])
				status.level <= fifo_pkg::LEVEL_HIGH;
			else
				status.level <= fifo_pkg::level_e'(cnt_nxt[ADDR_WIDTH-1 -: 2]);
		end
	end

	//////////////////////////////
	// checks

	a_cnt_range: assert property (@(posedge clk) disable iff (!rst)
		int'(cnt) <= DEPTH)
		else $error("fifo_ctrl: count above depth");

	a_full_empty: assert property (@(posedge clk) disable iff (!rst)
		!(status.full && status.empty))
		else $error("fifo_ctrl: full and empty both set");

	// read stage must wait for stored data
	a_rd_avail: assert property (@(posedge clk) disable iff (!rst)
		rd_en |-> rd_avail)
		else $error("fifo_ctrl: read issued with nothing available");

endmodule

`default_nettype wire

/* verilog/fifo_pkg.sv */
`default_nettype none

// status types of the FIFO controller
package fifo_pkg;

	//////////////////////////////
	// fill level

	// coarse occupancy in quarters of the depth
	// top two bits of the count, overflow bit forces the high quarter
	typedef enum logic [1:0] {
		LEVEL_LOW     = 2'd0,
		LEVEL_QUARTER = 2'd1,
		LEVEL_HALF    = 2'd2,
		LEVEL_HIGH    = 2'd3
	} level_e;

	//////////////////////////////
	// status word

	// all fields are registered in fifo_ctrl
	typedef struct packed {
		logic   full;
		logic   empty;
		logic   almost_full;
		logic   almost_empty;
		level_e level;
	} fifo_status_t;

endpackage

`default_nettype wire

/* verilog/fifo_ram.sv */
`default_nettype none

// simple dual-port RAM, one write port and one registered read port
module fifo_ram #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                  clk,
	input  logic                  wr_en,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  stream_pkg::beat_t     wr_data,
	input  logic                  rd_en,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output stream_pkg::beat_t     rd_data
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	// storage array, no reset on payload
	stream_pkg::beat_t mem [DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read port, one cycle of latency
	// output holds its value when no read is issued
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* verilog/fifo_read_stage.sv */
`default_nettype none

// issues RAM reads and holds up to two beats behind a valid/ready port
module fifo_read_stage (
	input  logic              clk,
	input  logic              rst,
	input  logic              clr,
	input  logic              rd_avail,
	input  stream_pkg::beat_t rd_data,
	output logic              rd_en,
	output stream_pkg::beat_t out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	// beats held in the output buffer
	typedef enum logic [1:0] {
		FILL_NONE = 2'd0,
		FILL_ONE  = 2'd1,
		FILL_TWO  = 2'd2
	} fill_e;

	fill_e             fill;
	// one RAM read issued last edge, data arrives now
	logic              inflight;
	logic              pop;
	logic              push;
	logic [1:0]        held;
	logic [1:0]        held_pop;
	logic [1:0]        budget;
	// head drives the port, tail is the second entry
	stream_pkg::beat_t head;
	stream_pkg::beat_t tail;

	assign held      = fill;
	assign out_valid = fill != FILL_NONE;
	assign out_data  = head;

	assign pop  = out_valid & out_ready;
	assign push = inflight;

	// beats left after this cycle's pop, then the read in flight on top
	assign held_pop = held - {1'b0, pop};
	assign budget   = held_pop + {1'b0, inflight};

	// stay at most two beats ahead of the consumer
	assign rd_en = rd_avail & (budget < 2'd2);

	//////////////////////////////
	// control state

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			fill     <= FILL_NONE;
			inflight <= 1'b0;
		end else begin
			fill     <= fill_e'(held_pop + {1'b0, push});
			inflight <= rd_en;
		end
	end

	//////////////////////////////
	// output buffer

	always_ff @(posedge clk) begin
		// shift up on a pop
		if (pop)
			head <= tail;
		// new beat lands in the first free entry
		// overrides the shift when the buffer drains to nothing
		if (push) begin
			if (held_pop == 2'd0)
				head <= rd_data;
			else
				tail <= rd_data;
		end
	end

	// held beats plus the read in flight fit the two entries
	a_budget: assert property (@(posedge clk) disable iff (!rst)
		(3'(held) + 3'(inflight)) <= 3'd2)
		else $error("fifo_read_stage: output buffer overcommitted");

endmodule

`default_nettype wire

/* verilog/stream_fifo_top.sv */
`default_nettype none

// stream FIFO, controller plus RAM plus output read stage
module stream_fifo_top #(
	parameter int ADDR_WIDTH = 4,
	parameter int AEMPTY_TH  = 2,
	parameter int AFULL_TH   = 2
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   clr,
	input  stream_pkg::beat_t      in_data,
	input  logic                   in_valid,
	output logic                   in_ready,
	output stream_pkg::beat_t      out_data,
	output logic                   out_valid,
	input  logic                   out_ready,
	output fifo_pkg::fifo_status_t status
);

	logic                  wr_en;
	logic [ADDR_WIDTH-1:0] wr_addr;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic                  rd_en;
	logic                  rd_avail;
	stream_pkg::beat_t     rd_data;

	// same inverted full that gates wr_en in the controller
	assign in_ready = ~status.full;

	fifo_ctrl #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.AEMPTY_TH (AEMPTY_TH),
		.AFULL_TH  (AFULL_TH)
	) i_fifo_ctrl (
		.clk     (clk),
		.rst     (rst),
		.clr     (clr),
		.wr_req  (in_valid),
		.rd_en   (rd_en),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.rd_addr (rd_addr),
		.rd_avail(rd_avail),
		.status  (status)
	);

	fifo_ram #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_fifo_ram (
		.clk    (clk),
		.wr_en  (wr_en),
		.wr_addr(wr_addr),
		.wr_data(in_data),
		.rd_en  (rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	fifo_read_stage i_fifo_read_stage (
		.clk      (clk),
		.rst      (rst),
		.clr      (clr),
		.rd_avail (rd_avail),
		.rd_data  (rd_data),
		.rd_en    (rd_en),
		.out_data (out_data),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

/* verilog/stream_pkg.sv */
`default_nettype none

// beat format shared by the stream ports, the RAM and the read stage
package stream_pkg;

	//////////////////////////////
	// beat layout

	// payload width of one beat
	localparam int BEAT_DATA_WIDTH = 128;

	// one beat on the stream, 129 bits in all
	// last marks the final beat of a packet and is carried through untouched
	typedef struct packed {
		logic [BEAT_DATA_WIDTH-1:0] data;
		logic                       last;
	} beat_t;

endpackage

`default_nettype wire
